/* cfgshadow_pkg.sv */
package cfgshadow_pkg;

    // ----------------------------------------------------------
    // Widths and depths
    // ----------------------------------------------------------
    localparam int CFG_ADDR_W     = 10;
    localparam int CFG_DATA_W     = 32;
    localparam int CFG_BE_W       = 4;
    localparam int TLP_W          = 128;
    localparam int KEEP_W         = TLP_W / CFG_DATA_W;
    localparam int PCIE_ID_W      = 16;
    localparam int CFG_WORDS      = 1 << CFG_ADDR_W;
    localparam int CPL_FIFO_DEPTH = 8;
    localparam int PIPE_DEPTH     = 3;
    localparam int CPL_PTR_W      = $clog2(CPL_FIFO_DEPTH);
    localparam int CPL_CNT_W      = $clog2(CPL_FIFO_DEPTH + 1);
    localparam int INFLIGHT_W     = $clog2(PIPE_DEPTH + 1);

    // ----------------------------------------------------------
    // Request TLP fields, LSB positions in the 128-bit beat
    // ----------------------------------------------------------
    localparam int FMT_TYPE_W    = 7;
    localparam int TLP_FMT_LSB   = 25;
    localparam int TLP_BE_LSB    = 32;
    localparam int TLP_TAG_LSB   = 40;
    localparam int TLP_REQID_LSB = 48;
    localparam int TLP_ADDR_LSB  = 66;
    localparam int TLP_DATA_LSB  = 96;

    localparam logic [FMT_TYPE_W-1:0] FMT_TYPE_CFGRD = 7'b0000010;
    localparam logic [FMT_TYPE_W-1:0] FMT_TYPE_CFGWR = 7'b0100010;

    // Completion header, length 1, status successful
    localparam logic [CFG_DATA_W-1:0] CPL_DW0_CPLD   = 32'h4A00_0001;
    localparam logic [CFG_DATA_W-1:0] CPL_DW0_CPL    = 32'h0A00_0001;
    localparam logic [15:0]           CPL_BYTE_COUNT = 16'h0004;
    localparam logic [KEEP_W-1:0]     KEEP_CPLD      = 4'b1111;
    localparam logic [KEEP_W-1:0]     KEEP_CPL       = 4'b0111;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_e;

    typedef struct packed {
        logic enable;
        logic write_enable;
        logic zero_reads;
    } cfg_ctrl_t;

    localparam cfg_ctrl_t CTRL_RESET = '{enable: 1'b1, write_enable: 1'b1, zero_reads: 1'b0};

    typedef struct packed {
        req_kind_e              kind;
        logic [CFG_ADDR_W-1:0]  addr;
        logic [CFG_BE_W-1:0]    be;
        logic [CFG_DATA_W-1:0]  data;
        logic [7:0]             tag;
        logic [15:0]            reqid;
    } cfg_req_t;

    typedef struct packed {
        logic [TLP_W-1:0] tdata;
        logic             has_payload;
    } cfg_cpl_t;

    // ----------------------------------------------------------
    // Write mask
    // ----------------------------------------------------------
    localparam int WRMASK_HDR_N = 16;

    // Header dwords, everything past them is fully writable
    localparam logic [CFG_DATA_W-1:0] WRMASK_HDR [0:WRMASK_HDR_N-1] = '{
        32'h0000_0000, 32'h0000_FFFF, 32'h0000_0000, 32'h0000_00FF,
        32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
        32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_00FF
    };

    function automatic logic [CFG_DATA_W-1:0] cfg_wrmask(input logic [CFG_ADDR_W-1:0] addr);
        if (addr < CFG_ADDR_W'(WRMASK_HDR_N)) begin
            return WRMASK_HDR[addr[3:0]];
        end
        return '1;
    endfunction

endpackage

/* cfg_ctrl_regs.sv */
`timescale 1ns/1ps

module cfg_ctrl_regs (
    input  logic                     clk_pcie,
    input  logic                     rst,
    input  logic                     i_ctrl_wr,
    input  cfgshadow_pkg::cfg_ctrl_t i_ctrl_data,
    output cfgshadow_pkg::cfg_ctrl_t o_ctrl
);
    import cfgshadow_pkg::*;

    // Control bits, loaded by a single write strobe
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            o_ctrl <= CTRL_RESET;
        end else if (i_ctrl_wr) begin
            o_ctrl <= i_ctrl_data;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    // Datapath steering must stay known once out of reset
    a_ctrl_known: assert property (
        @(posedge clk_pcie) disable iff (rst)
        !$isunknown(o_ctrl)
    ) else $error("control bits unknown after reset");

endmodule

/* cfg_tlp_decode.sv */
`timescale 1ns/1ps

module cfg_tlp_decode (
    input  logic                             clk_pcie,
    input  logic                             rst,
    input  logic                             i_tlp_valid,
    input  logic [cfgshadow_pkg::TLP_W-1:0]  i_tlp_data,
    output logic                             o_tlp_ready,
    input  logic                             i_enable,
    input  logic                             i_room,
    output logic                             o_req_valid,
    output cfgshadow_pkg::cfg_req_t          o_req
);
    import cfgshadow_pkg::*;

    logic [FMT_TYPE_W-1:0] fmt_type;
    logic                  accept;
    logic                  is_cfg;
    cfg_req_t              req_d;

    // Back-pressure follows the room signal from the completion side
    assign o_tlp_ready = i_room;
    assign accept      = i_tlp_valid && i_room;
    assign fmt_type    = i_tlp_data[TLP_FMT_LSB +: FMT_TYPE_W];

    // ----------------------------------------------------------
    // Classify and unpack
    // ----------------------------------------------------------
    always_comb begin
        is_cfg      = 1'b1;
        req_d.kind  = REQ_READ;
        case (fmt_type)
            FMT_TYPE_CFGRD: begin
                req_d.kind = REQ_READ;
            end
            FMT_TYPE_CFGWR: begin
                req_d.kind = REQ_WRITE;
            end
            default: begin
                is_cfg = 1'b0;
            end
        endcase

        req_d.addr  = i_tlp_data[TLP_ADDR_LSB +: CFG_ADDR_W];
        req_d.data  = i_tlp_data[TLP_DATA_LSB +: CFG_DATA_W];
        req_d.tag   = i_tlp_data[TLP_TAG_LSB +: 8];
        req_d.reqid = i_tlp_data[TLP_REQID_LSB +: 16];

        // First DW BE arrives bit-reversed in this beat layout
        for (int i = 0; i < CFG_BE_W; i++) begin
            req_d.be[i] = i_tlp_data[TLP_BE_LSB + CFG_BE_W - 1 - i];
        end
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------

    // Unsupported beats and anything seen while disabled are consumed silently
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= accept && is_cfg && i_enable;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (accept) begin
            o_req <= req_d;
        end
    end

endmodule

/* cfg_shadow_ram.sv */
`timescale 1ns/1ps

module cfg_shadow_ram (
    input  logic                                   clk_pcie,
    input  logic                                   rst,
    input  logic                                   i_req_valid,
    input  cfgshadow_pkg::cfg_req_t                i_req,
    input  logic                                   i_write_enable,
    output logic                                   o_rd_valid,
    output cfgshadow_pkg::cfg_req_t                o_rd_req,
    output logic [cfgshadow_pkg::CFG_DATA_W-1:0]   o_rd_data
);
    import cfgshadow_pkg::*;

    localparam int BYTE_W = CFG_DATA_W / CFG_BE_W;

    // 4 KB shadow with one dword per entry
    logic [CFG_DATA_W-1:0] mem [0:CFG_WORDS-1];

    logic                  wr_allow_q;
    logic                  wr_fire;
    logic                  fwd_hit;
    logic [CFG_DATA_W-1:0] be_mask;
    logic [CFG_DATA_W-1:0] bit_mask;
    logic [CFG_DATA_W-1:0] merged;

    // ----------------------------------------------------------
    // Merge on the second cycle
    // ----------------------------------------------------------
    always_comb begin
        for (int b = 0; b < CFG_BE_W; b++) begin
            be_mask[b*BYTE_W +: BYTE_W] = {BYTE_W{o_rd_req.be[b]}};
        end
    end

    // New bit only where both the mask rule and the byte enable allow it
    assign bit_mask = be_mask & cfg_wrmask(o_rd_req.addr);
    assign merged   = (o_rd_req.data & bit_mask) | (o_rd_data & ~bit_mask);

    assign wr_fire  = o_rd_valid && (o_rd_req.kind == REQ_WRITE) && wr_allow_q;

    // Next request hits the word being written at this edge
    assign fwd_hit  = wr_fire && (o_rd_req.addr == i_req.addr);

    // ----------------------------------------------------------
    // Pipeline registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_req_valid;
        end
    end

    // write_enable is sampled together with the request it applies to
    always_ff @(posedge clk_pcie) begin
        o_rd_req   <= i_req;
        wr_allow_q <= i_write_enable;
    end

    // ----------------------------------------------------------
    // RAM array
    // ----------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (wr_fire) begin
            mem[o_rd_req.addr] <= merged;
        end
        if (fwd_hit) begin
            o_rd_data <= merged;
        end else begin
            o_rd_data <= mem[i_req.addr];
        end
    end

endmodule

/* cfg_cpl_builder.sv */
`timescale 1ns/1ps

module cfg_cpl_builder (
    input  logic                                   clk_pcie,
    input  logic                                   rst,
    input  logic [cfgshadow_pkg::PCIE_ID_W-1:0]    i_pcie_id,
    input  logic                                   i_zero_reads,
    input  logic                                   i_rd_valid,
    input  cfgshadow_pkg::cfg_req_t                i_rd_req,
    input  logic [cfgshadow_pkg::CFG_DATA_W-1:0]   i_rd_data,
    input  logic                                   i_decode_busy,
    output logic                                   o_room,
    output logic                                   o_cpl_valid,
    output logic [cfgshadow_pkg::TLP_W-1:0]        o_cpl_data,
    output logic [cfgshadow_pkg::KEEP_W-1:0]       o_cpl_keep_dw,
    input  logic                                   i_cpl_ready
);
    import cfgshadow_pkg::*;

    cfg_cpl_t              fifo_mem [0:CPL_FIFO_DEPTH-1];
    cfg_cpl_t              cpl_d;
    cfg_cpl_t              head;
    logic [CPL_PTR_W-1:0]  wr_ptr;
    logic [CPL_PTR_W-1:0]  rd_ptr;
    logic [CPL_CNT_W-1:0]  count;
    logic [CPL_CNT_W-1:0]  free_slots;
    logic [INFLIGHT_W-1:0] in_flight;
    logic                  push;
    logic                  pop;
    logic [CFG_DATA_W-1:0] dw0;
    logic [CFG_DATA_W-1:0] dw1;
    logic [CFG_DATA_W-1:0] dw2;
    logic [CFG_DATA_W-1:0] dw3;

    // ----------------------------------------------------------
    // Completion formatting
    // ----------------------------------------------------------
    always_comb begin
        // Completer ID goes out byte-swapped
        dw1 = {i_pcie_id[7:0], i_pcie_id[15:8], CPL_BYTE_COUNT};
        dw2 = {i_rd_req.reqid, i_rd_req.tag, 8'h00};
        if (i_rd_req.kind == REQ_READ) begin
            dw0               = CPL_DW0_CPLD;
            dw3               = i_zero_reads ? '0 : i_rd_data;
            cpl_d.has_payload = 1'b1;
        end else begin
            dw0               = CPL_DW0_CPL;
            dw3               = '0;
            cpl_d.has_payload = 1'b0;
        end
        cpl_d.tdata = {dw3, dw2, dw1, dw0};
    end

    // ----------------------------------------------------------
    // Completion FIFO
    // ----------------------------------------------------------
    assign push = i_rd_valid;
    assign pop  = o_cpl_valid && i_cpl_ready;

    always_ff @(posedge clk_pcie) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cpl_d;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head          = fifo_mem[rd_ptr];
    assign o_cpl_valid   = (count != '0);
    assign o_cpl_data    = head.tdata;
    assign o_cpl_keep_dw = head.has_payload ? KEEP_CPLD : KEEP_CPL;

    // ----------------------------------------------------------
    // Credit check for the request side
    // ----------------------------------------------------------

    // Every request in decode or RAM still needs its own slot
    assign in_flight  = INFLIGHT_W'(i_decode_busy) + INFLIGHT_W'(i_rd_valid);
    assign free_slots = CPL_CNT_W'(CPL_FIFO_DEPTH) - count;
    assign o_room     = free_slots > CPL_CNT_W'(in_flight);

    a_no_push_full: assert property (
        @(posedge clk_pcie) disable iff (rst)
        push |-> (count != CPL_CNT_W'(CPL_FIFO_DEPTH)) || pop
    ) else $error("completion FIFO pushed while full");

endmodule

/* cfg_shadow_top.sv */
`timescale 1ns/1ps

module cfg_shadow_top (
    input  logic                                 clk_pcie,
    input  logic                                 rst,
    input  logic [cfgshadow_pkg::PCIE_ID_W-1:0]  i_pcie_id,
    input  logic                                 i_ctrl_wr,
    input  cfgshadow_pkg::cfg_ctrl_t             i_ctrl_data,
    input  logic                                 i_tlp_valid,
    output logic                                 o_tlp_ready,
    input  logic [cfgshadow_pkg::TLP_W-1:0]      i_tlp_data,
    output logic                                 o_cpl_valid,
    input  logic                                 i_cpl_ready,
    output logic [cfgshadow_pkg::TLP_W-1:0]      o_cpl_data,
    output logic [cfgshadow_pkg::KEEP_W-1:0]     o_cpl_keep_dw
);
    import cfgshadow_pkg::*;

    cfg_ctrl_t             ctrl;
    logic                  room;
    logic                  req_valid;
    cfg_req_t              req;
    logic                  rd_valid;
    cfg_req_t              rd_req;
    logic [CFG_DATA_W-1:0] rd_data;

    cfg_ctrl_regs u_ctrl (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_ctrl_wr   (i_ctrl_wr),
        .i_ctrl_data (i_ctrl_data),
        .o_ctrl      (ctrl)
    );

    cfg_tlp_decode u_decode (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_tlp_valid (i_tlp_valid),
        .i_tlp_data  (i_tlp_data),
        .o_tlp_ready (o_tlp_ready),
        .i_enable    (ctrl.enable),
        .i_room      (room),
        .o_req_valid (req_valid),
        .o_req       (req)
    );

    cfg_shadow_ram u_ram (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .i_req_valid    (req_valid),
        .i_req          (req),
        .i_write_enable (ctrl.write_enable),
        .o_rd_valid     (rd_valid),
        .o_rd_req       (rd_req),
        .o_rd_data      (rd_data)
    );

    cfg_cpl_builder u_cpl (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .i_pcie_id     (i_pcie_id),
        .i_zero_reads  (ctrl.zero_reads),
        .i_rd_valid    (rd_valid),
        .i_rd_req      (rd_req),
        .i_rd_data     (rd_data),
        .i_decode_busy (req_valid),
        .o_room        (room),
        .o_cpl_valid   (o_cpl_valid),
        .o_cpl_data    (o_cpl_data),
        .o_cpl_keep_dw (o_cpl_keep_dw),
        .i_cpl_ready   (i_cpl_ready)
    );

endmodule

/* tb_cfg_shadow.sv */
`timescale 1ns/1ps

module tb_cfg_shadow;
    import cfgshadow_pkg::*;

    localparam int          READY_TIMEOUT = 100;
    localparam int          DRAIN_TIMEOUT = 400;
    localparam int          FIFO_SLOTS    = 8;
    localparam logic [6:0]  CODE_RD       = 7'b0000010;
    localparam logic [6:0]  CODE_WR       = 7'b0100010;
    localparam logic [6:0]  CODE_BAD      = 7'b1000000;
    localparam logic [15:0] DEV_ID        = 16'hA5C3;

    logic         clk_pcie;
    logic         rst;
    logic [15:0]  i_pcie_id;
    logic         i_ctrl_wr;
    cfg_ctrl_t    i_ctrl_data;
    logic         i_tlp_valid;
    logic         o_tlp_ready;
    logic [127:0] i_tlp_data;
    logic         o_cpl_valid;
    logic         i_cpl_ready;
    logic [127:0] o_cpl_data;
    logic [3:0]   o_cpl_keep_dw;

    // Model state
    cfg_ctrl_t    model_ctrl;
    logic [31:0]  ref_mem [0:1023];
    cfg_cpl_t     exp_q [$];
    integer       seed = 32'h00915bae;

    cfg_shadow_top DUT (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .i_pcie_id     (i_pcie_id),
        .i_ctrl_wr     (i_ctrl_wr),
        .i_ctrl_data   (i_ctrl_data),
        .i_tlp_valid   (i_tlp_valid),
        .o_tlp_ready   (o_tlp_ready),
        .i_tlp_data    (i_tlp_data),
        .o_cpl_valid   (o_cpl_valid),
        .i_cpl_ready   (i_cpl_ready),
        .o_cpl_data    (o_cpl_data),
        .o_cpl_keep_dw (o_cpl_keep_dw)
    );

    initial begin
        clk_pcie = 1'b0;
        forever #4 clk_pcie = ~clk_pcie;
    end

    // ----------------------------------------------------------
    // Reporting and compares
    // ----------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("error at %0t ns: %s", $time, msg));
    endtask

    task automatic check_cpl(input logic [127:0] got_data, input logic [3:0] got_keep,
                             input cfg_cpl_t exp);
        logic [3:0] exp_keep;
        exp_keep = exp.has_payload ? 4'b1111 : 4'b0111;
        if (got_keep !== exp_keep) begin
            value_error($sformatf("keep_dw %b, expected %b", got_keep, exp_keep));
        end
        if (got_data !== exp.tdata) begin
            value_error($sformatf("completion %h, expected %h", got_data, exp.tdata));
        end
    endtask

    task automatic check_ctrl(input cfg_ctrl_t got, input cfg_ctrl_t exp);
        if (got !== exp) begin
            value_error($sformatf("control bits %b, expected %b", got, exp));
        end
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] header_mask(input logic [9:0] addr);
        if (addr >= 10'd16) begin
            return '1;
        end
        case (addr[3:0])
            4'd1:                               return 32'h0000_FFFF;
            4'd3, 4'd15:                        return 32'h0000_00FF;
            4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9: return 32'hFFFF_FFFF;
            default:                            return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [127:0] make_tlp(input logic [6:0] code, input logic [9:0] addr,
                                              input logic [3:0] be, input logic [31:0] data,
                                              input logic [7:0] tag, input logic [15:0] reqid);
        logic [127:0] tlp;
        tlp          = '0;
        tlp[9:0]     = 10'd1;
        tlp[31:25]   = code;
        // First DW BE sits bit-reversed
        for (int i = 0; i < 4; i++) begin
            tlp[35 - i] = be[i];
        end
        tlp[47:40]   = tag;
        tlp[63:48]   = reqid;
        tlp[75:66]   = addr;
        tlp[127:96]  = data;
        return tlp;
    endfunction

    function automatic cfg_cpl_t ref_cpl(input logic is_wr, input logic [9:0] addr,
                                         input logic [3:0] be, input logic [31:0] data,
                                         input logic [7:0] tag, input logic [15:0] reqid);
        cfg_cpl_t    cpl;
        logic [31:0] upd_bits;
        logic [31:0] payload;
        upd_bits = header_mask(addr) & {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        payload  = '0;
        if (is_wr) begin
            if (model_ctrl.write_enable) begin
                ref_mem[addr] = (data & upd_bits) | (ref_mem[addr] & ~upd_bits);
            end
        end else if (!model_ctrl.zero_reads) begin
            payload = ref_mem[addr];
        end
        // CplD uses fmt 010 and Cpl fmt 000 with type 01010 and length 1
        cpl.has_payload = !is_wr;
        cpl.tdata = {payload, reqid, tag, 8'h00, DEV_ID[7:0], DEV_ID[15:8], 16'd4,
                     (is_wr ? 3'b000 : 3'b010), 5'b01010, 14'd0, 10'd1};
        return cpl;
    endfunction

    // Every completion handshake against the oldest expected one
    always @(posedge clk_pcie) begin
        if (!rst && o_cpl_valid && i_cpl_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a completion came out while none was outstanding");
            end else begin
                check_cpl(o_cpl_data, o_cpl_keep_dw, exp_q.pop_front());
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus tasks start and end 1 ns after an edge
    // ----------------------------------------------------------
    task automatic issue(input logic [6:0] code, input logic [9:0] addr,
                         input logic [3:0] be, input logic [31:0] data);
        logic [7:0]  tag;
        logic [15:0] reqid;
        int          waited;
        tag         = $random(seed);
        reqid       = $random(seed);
        waited      = 0;
        i_tlp_data  = make_tlp(code, addr, be, data, tag, reqid);
        i_tlp_valid = 1'b1;
        @(posedge clk_pcie);
        while (!o_tlp_ready) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("timed out waiting for the DUT to accept a request");
            end
            @(posedge clk_pcie);
        end
        #1;
        i_tlp_valid = 1'b0;
        if (model_ctrl.enable && (code == CODE_RD || code == CODE_WR)) begin
            exp_q.push_back(ref_cpl(code == CODE_WR, addr, be, data, tag, reqid));
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_pcie);
            #1;
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timed out waiting for the expected completions");
            end
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk_pcie);
            #1;
            if (o_cpl_valid) begin
                abort_run("a completion appeared where none was expected");
            end
        end
    endtask

    task automatic set_ctrl(input logic en, input logic we, input logic zr);
        i_ctrl_data = '{enable: en, write_enable: we, zero_reads: zr};
        i_ctrl_wr   = 1'b1;
        @(posedge clk_pcie);
        #1;
        i_ctrl_wr   = 1'b0;
        model_ctrl  = i_ctrl_data;
        check_ctrl(DUT.ctrl, model_ctrl);
    endtask

    // Hold off completions until the request side stalls
    task automatic stall_and_release();
        logic [7:0]  tag;
        logic [15:0] reqid;
        logic [9:0]  addr;
        logic        stalled;
        int          taken;
        int          waited;
        stalled     = 1'b0;
        taken       = 0;
        waited      = 0;
        i_cpl_ready = 1'b0;
        while (!stalled) begin
            tag         = $random(seed);
            reqid       = $random(seed);
            addr        = 10'd16 + ($random(seed) & 10'h1FF);
            i_tlp_data  = make_tlp(CODE_RD, addr, 4'hF, '0, tag, reqid);
            i_tlp_valid = 1'b1;
            @(posedge clk_pcie);
            stalled = !o_tlp_ready;
            #1;
            if (!stalled) begin
                exp_q.push_back(ref_cpl(1'b0, addr, 4'hF, '0, tag, reqid));
                taken++;
            end
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("timed out waiting for o_tlp_ready to fall under back-pressure");
            end
        end
        i_tlp_valid = 1'b0;
        if (taken != FIFO_SLOTS) begin
            value_error($sformatf("%0d requests accepted before stall, expected %0d",
                                  taken, FIFO_SLOTS));
        end
        i_cpl_ready = 1'b1;
        drain();
        expect_quiet(10);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        logic [9:0] addr;
        rst         = 1'b1;
        i_pcie_id   = DEV_ID;
        i_ctrl_wr   = 1'b0;
        i_ctrl_data = '0;
        i_tlp_valid = 1'b0;
        i_tlp_data  = '0;
        i_cpl_ready = 1'b1;
        model_ctrl  = '{enable: 1'b1, write_enable: 1'b1, zero_reads: 1'b0};
        repeat (5) @(posedge clk_pcie);
        #1;
        rst = 1'b0;
        check_ctrl(DUT.ctrl, model_ctrl);

        // Fully writable dwords
        for (int a = 16; a < 1024; a++) begin
            issue(CODE_WR, a[9:0], 4'hF, $random(seed));
        end
        for (int a = 16; a < 1024; a++) begin
            issue(CODE_RD, a[9:0], 4'hF, '0);
        end
        drain();

        // Header dwords with random byte enables
        repeat (3) begin
            for (int a = 0; a < 16; a++) begin
                issue(CODE_WR, a[9:0], $random(seed), $random(seed));
            end
            for (int a = 0; a < 16; a++) begin
                issue(CODE_RD, a[9:0], 4'hF, '0);
            end
        end
        drain();

        // Same address with no idle cycles
        for (int n = 0; n < 40; n++) begin
            addr = $random(seed);
            issue(CODE_WR, addr, $random(seed), $random(seed));
            issue(CODE_RD, addr, 4'hF, '0);
            issue(CODE_WR, addr, 4'hF, $random(seed));
            issue(CODE_RD, addr, 4'hF, '0);
        end
        drain();

        stall_and_release();

        // Control bits
        set_ctrl(1'b0, 1'b1, 1'b0);
        issue(CODE_WR, 10'd100, 4'hF, 32'hDEAD_BEEF);
        issue(CODE_RD, 10'd100, 4'hF, '0);
        expect_quiet(20);
        set_ctrl(1'b1, 1'b0, 1'b0);
        issue(CODE_RD, 10'd100, 4'hF, '0);
        issue(CODE_WR, 10'd200, 4'hF, $random(seed));
        issue(CODE_RD, 10'd200, 4'hF, '0);
        drain();
        set_ctrl(1'b1, 1'b1, 1'b1);
        issue(CODE_RD, 10'd300, 4'hF, '0);
        issue(CODE_WR, 10'd300, 4'hF, $random(seed));
        issue(CODE_RD, 10'd300, 4'hF, '0);
        drain();
        set_ctrl(1'b1, 1'b1, 1'b0);
        issue(CODE_RD, 10'd300, 4'hF, '0);
        drain();
        issue(CODE_BAD, 10'd40, 4'hF, $random(seed));
        expect_quiet(20);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* vlog.f */
cfgshadow_pkg.sv
cfg_ctrl_regs.sv
cfg_tlp_decode.sv
cfg_shadow_ram.sv
cfg_cpl_builder.sv
cfg_shadow_top.sv
tb_cfg_shadow.sv
